/* mem_agg_pkg.sv */
`default_nettype none

// ===========================================================================
// Shared widths, counts and types for the sliced memory
// ===========================================================================

package mem_agg_pkg;

    // -----------------------------------------------------------------------
    // Address space
    // -----------------------------------------------------------------------

    // Address bits, same for controller and slices
    localparam int ADDR_WID = 5;

    // Entries per slice, one per address
    localparam int DEPTH = 2 ** ADDR_WID;

    // -----------------------------------------------------------------------
    // Data widths
    // -----------------------------------------------------------------------

    // Number of narrow RAM slices side by side
    localparam int N_SLICE = 4;

    // Width of one slice
    localparam int SLICE_WID = 16;

    // Controller word, all slices joined
    localparam int WORD_WID = N_SLICE * SLICE_WID;

    // -----------------------------------------------------------------------
    // Timing
    // -----------------------------------------------------------------------

    // Read strobe to rd_vld, in clock cycles
    // Request register, slice read register, output register
    localparam int RD_LATENCY = 3;

    // -----------------------------------------------------------------------
    // Vector types
    // -----------------------------------------------------------------------

    // Word address
    typedef logic [ADDR_WID-1:0] addr_t;

    // Full controller word
    typedef logic [WORD_WID-1:0] word_t;

    // Data of one slice
    typedef logic [SLICE_WID-1:0] slice_t;

endpackage : mem_agg_pkg

`default_nettype wire

/* mem_aggregate.sv */
`timescale 1ns/10ps
`default_nettype none

// ===========================================================================
// Wide memory top, four narrow slices
// ===========================================================================

module mem_aggregate (
    input  wire logic               clk,
    input  wire logic               arst_n,
    // Controller write
    input  wire logic               wr_en,
    input  wire mem_agg_pkg::addr_t wr_addr,
    input  wire mem_agg_pkg::word_t wr_data,
    // Controller read
    input  wire logic               rd_en,
    input  wire mem_agg_pkg::addr_t rd_addr,
    output wire logic               rd_vld,
    output mem_agg_pkg::word_t      rd_data,
    // Init done
    output wire logic               rdy
);

    // Write side to slices
    logic                s_wr_en;
    mem_agg_pkg::addr_t  s_wr_addr;
    mem_agg_pkg::slice_t s_wr_data [mem_agg_pkg::N_SLICE];

    // Read side to and from slices
    logic                s_rd_en;
    mem_agg_pkg::addr_t  s_rd_addr;
    mem_agg_pkg::slice_t s_rd_data [mem_agg_pkg::N_SLICE];

    // Init FSM and word split
    mem_wr_aggregate wr_aggregate_i (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .wr_en     ( wr_en ),
        .wr_addr   ( wr_addr ),
        .wr_data   ( wr_data ),
        .rdy       ( rdy ),
        .s_wr_en   ( s_wr_en ),
        .s_wr_addr ( s_wr_addr ),
        .s_wr_data ( s_wr_data )
    );

    // Slices share address and strobes, own a data lane each
    generate
        for (genvar i = 0; i < mem_agg_pkg::N_SLICE; i++) begin : g_slice
            mem_ram_sdp ram_i (
                .clk       ( clk ),
                .s_wr_en   ( s_wr_en ),
                .s_wr_addr ( s_wr_addr ),
                .s_wr_data ( s_wr_data[i] ),
                .s_rd_en   ( s_rd_en ),
                .s_rd_addr ( s_rd_addr ),
                .s_rd_data ( s_rd_data[i] )
            );
        end : g_slice
    endgenerate

    // Fan-out of reads and word join
    mem_rd_aggregate rd_aggregate_i (
        .clk       ( clk ),
        .arst_n    ( arst_n ),
        .rdy       ( rdy ),
        .rd_en     ( rd_en ),
        .rd_addr   ( rd_addr ),
        .s_rd_en   ( s_rd_en ),
        .s_rd_addr ( s_rd_addr ),
        .s_rd_data ( s_rd_data ),
        .rd_vld    ( rd_vld ),
        .rd_data   ( rd_data )
    );

endmodule : mem_aggregate

`default_nettype wire

/* mem_aggregate_properties.sv */
`timescale 1ns/10ps
`default_nettype none

// ===========================================================================
// Top-level timing assertions, bound to mem_aggregate
// ===========================================================================

module mem_aggregate_properties (
    input wire logic clk,
    input wire logic arst_n,
    input wire logic rd_en,
    input wire logic rdy,
    input wire logic rd_vld
);

    // Init finishes once and stays done
    rdy_stays_high: assert property (
        @(posedge clk) disable iff (!arst_n)
        rdy |=> rdy
    ) else $error("rdy fell after it had risen");

    // No read result before the memory is usable
    no_vld_before_rdy: assert property (
        @(posedge clk) disable iff (!arst_n)
        !rdy |-> !rd_vld
    ) else $error("rd_vld seen while rdy is low");

    // Fixed read latency, request to result
    read_latency: assert property (
        @(posedge clk) disable iff (!arst_n)
        (rd_en && rdy) |-> ##(mem_agg_pkg::RD_LATENCY) rd_vld
    ) else $error("rd_vld missing RD_LATENCY cycles after an accepted read");

    // Every result traces back to an accepted read
    vld_has_read: assert property (
        @(posedge clk) disable iff (!arst_n)
        rd_vld |-> $past(rd_en && rdy, mem_agg_pkg::RD_LATENCY)
    ) else $error("rd_vld without an accepted read RD_LATENCY cycles earlier");

    // Output strobe held low in reset
    vld_low_in_reset: assert property (
        @(posedge clk)
        !arst_n |-> !rd_vld
    ) else $error("rd_vld high during reset");

endmodule : mem_aggregate_properties

`default_nettype wire

/* mem_aggregate_tb.sv */
`timescale 1ns/10ps
`default_nettype none

// ===========================================================================
// Testbench for the sliced wide memory
// ===========================================================================

module mem_aggregate_tb;

    // Clock and drive timing, ns
    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DLY  = 10;
    localparam int RST_CYCLES = 16;

    // Test lengths in cycles
    localparam int N_PRE = 20;
    localparam int N_B2B = 48;
    localparam int N_MIX = 400;

    // Strobe bound per test, two per cycle where both can fire
    localparam int N_STROBES = 2 * N_PRE + mem_agg_pkg::DEPTH + 2 + mem_agg_pkg::DEPTH
                               + N_B2B + 4 + 2 * N_MIX;
    localparam int TIMEOUT_CYC = 40 + 4 * N_STROBES;

    localparam int unsigned SEED = 32'h8adc_8f56;

    logic               clk;
    logic               arst_n;
    logic               wr_en;
    mem_agg_pkg::addr_t wr_addr;
    mem_agg_pkg::word_t wr_data;
    logic               rd_en;
    mem_agg_pkg::addr_t rd_addr;
    logic               rd_vld;
    mem_agg_pkg::word_t rd_data;
    logic               rdy;

    // Reference memory, one word per address
    mem_agg_pkg::word_t model [mem_agg_pkg::DEPTH];

    // Reads in flight, oldest first
    mem_agg_pkg::word_t exp_data_q [$];
    int                 exp_cyc_q [$];

    int    cyc = 0;
    string test_name;

    mem_aggregate dut_i (
        .clk     ( clk ),
        .arst_n  ( arst_n ),
        .wr_en   ( wr_en ),
        .wr_addr ( wr_addr ),
        .wr_data ( wr_data ),
        .rd_en   ( rd_en ),
        .rd_addr ( rd_addr ),
        .rd_vld  ( rd_vld ),
        .rd_data ( rd_data ),
        .rdy     ( rdy )
    );

    bind mem_aggregate mem_aggregate_properties props_i (
        .clk    ( clk ),
        .arst_n ( arst_n ),
        .rd_en  ( rd_en ),
        .rdy    ( rdy ),
        .rd_vld ( rd_vld )
    );

    // =======================================================================
    // Helpers
    // =======================================================================

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", what, expected, actual);
            abort_run("Value mismatch");
        end
    endtask

    function automatic mem_agg_pkg::addr_t rand_addr();
        return mem_agg_pkg::addr_t'($urandom() % mem_agg_pkg::DEPTH);
    endfunction

    function automatic mem_agg_pkg::word_t rand_word();
        return {$urandom(), $urandom()};
    endfunction

    // One cycle of stimulus, updates the model as the DUT will see it
    task automatic drive_cycle(input logic we, input mem_agg_pkg::addr_t wa,
                               input mem_agg_pkg::word_t wd, input logic re,
                               input mem_agg_pkg::addr_t ra);
        @(posedge clk);
        #(DRIVE_DLY);
        wr_en   = we;
        wr_addr = wa;
        wr_data = wd;
        rd_en   = re;
        rd_addr = ra;
        // rdy is steady here and holds until the sampling edge
        // Read takes the model before a same-cycle write
        if (rdy && re) begin
            exp_data_q.push_back(model[ra]);
            exp_cyc_q.push_back(cyc);
        end
        if (rdy && we) begin
            model[wa] = wd;
        end
    endtask

    task automatic drive_idle(input int n);
        repeat (n) drive_cycle(1'b0, '0, '0, 1'b0, '0);
    endtask

    // Bounded wait for the reads in flight
    task automatic wait_reads();
        int n;
        n = 0;
        while (exp_data_q.size() != 0 && n < mem_agg_pkg::RD_LATENCY + 2) begin
            @(posedge clk);
            n++;
        end
    endtask

    task automatic read_all();
        for (int a = 0; a < mem_agg_pkg::DEPTH; a++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, mem_agg_pkg::addr_t'(a));
        end
        drive_idle(1);
        wait_reads();
    endtask

    // =======================================================================
    // Clock, cycle count, result monitor
    // =======================================================================

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            abort_run($sformatf("Timeout, run still going after %0d cycles", TIMEOUT_CYC));
        end
    end

    // Mid-cycle sample, rd_vld and rd_data settled
    always @(negedge clk) begin
        if (rd_vld) begin
            if (exp_data_q.size() == 0) begin
                abort_run("rd_vld came with no read outstanding");
            end else begin
                check_value({test_name, " latency"}, mem_agg_pkg::RD_LATENCY,
                            cyc - exp_cyc_q.pop_front());
                check_value({test_name, " data"}, exp_data_q.pop_front(), rd_data);
            end
        end
    end

    // =======================================================================
    // Test sequence
    // =======================================================================

    initial begin
        mem_agg_pkg::addr_t a;
        mem_agg_pkg::word_t w0;
        void'($urandom(SEED));
        test_name = "reset";
        arst_n    = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        rd_en     = 1'b0;
        rd_addr   = '0;
        for (int i = 0; i < mem_agg_pkg::DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (RST_CYCLES) @(posedge clk);
        #(DRIVE_DLY);
        arst_n = 1'b1;

        // Strobes during the clear sweep, all dropped
        test_name = "pre_rdy";
        for (int i = 0; i < N_PRE; i++) begin
            drive_cycle(1'b1, rand_addr(), rand_word(), 1'b1, rand_addr());
        end
        drive_idle(1);
        while (!rdy) @(posedge clk);

        // Whole memory reads back zero
        test_name = "init_zero";
        read_all();

        // Split and join over all slices
        test_name = "single_wr_rd";
        a  = rand_addr();
        w0 = rand_word();
        drive_cycle(1'b1, a, w0, 1'b0, '0);
        drive_idle(1);
        drive_cycle(1'b0, '0, '0, 1'b1, a);
        drive_idle(1);
        wait_reads();

        // Fill with random words, then reads every cycle
        test_name = "b2b_reads";
        for (int i = 0; i < mem_agg_pkg::DEPTH; i++) begin
            drive_cycle(1'b1, mem_agg_pkg::addr_t'(i), rand_word(), 1'b0, '0);
        end
        for (int i = 0; i < N_B2B; i++) begin
            drive_cycle(1'b0, '0, '0, 1'b1, rand_addr());
        end
        drive_idle(1);
        wait_reads();

        // Write and read at one address in one cycle
        test_name = "collision";
        a  = rand_addr();
        w0 = rand_word();
        drive_cycle(1'b1, a, w0, 1'b0, '0);
        drive_idle(1);
        drive_cycle(1'b1, a, ~w0, 1'b1, a);
        drive_cycle(1'b0, '0, '0, 1'b1, a);
        drive_idle(1);
        wait_reads();

        test_name = "random_mix";
        for (int i = 0; i < N_MIX; i++) begin
            drive_cycle(1'($urandom() % 2), rand_addr(), rand_word(),
                        1'($urandom() % 2), rand_addr());
        end
        drive_idle(1);
        wait_reads();

        drive_idle(2);
        if (exp_data_q.size() != 0) begin
            abort_run($sformatf("%0d reads never returned rd_vld", exp_data_q.size()));
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule : mem_aggregate_tb

`default_nettype wire

/* mem_ram_sdp.sv */
`timescale 1ns/10ps
`default_nettype none

// ===========================================================================
// One RAM slice, simple dual port
// ===========================================================================

// 32 x 16 storage
// Write port and read port share clk
// Read returns old data when both ports hit one address at one edge

module mem_ram_sdp (
    input  wire logic                clk,
    // Write port
    input  wire logic                s_wr_en,
    input  wire mem_agg_pkg::addr_t  s_wr_addr,
    input  wire mem_agg_pkg::slice_t s_wr_data,
    // Read port
    input  wire logic                s_rd_en,
    input  wire mem_agg_pkg::addr_t  s_rd_addr,
    output mem_agg_pkg::slice_t      s_rd_data
);

    // -----------------------------------------------------------------------
    // Storage
    // -----------------------------------------------------------------------

    // Contents cleared by the write side sweep after reset
    mem_agg_pkg::slice_t mem [mem_agg_pkg::DEPTH];

    // -----------------------------------------------------------------------
    // Write port
    // -----------------------------------------------------------------------

    // Array updated at the edge ending the strobe cycle
    always_ff @(posedge clk) begin
        if (s_wr_en) begin
            mem[s_wr_addr] <= s_wr_data;
        end
    end

    // -----------------------------------------------------------------------
    // Read port
    // -----------------------------------------------------------------------

    // Registered read, one cycle after s_rd_en
    // Samples the array before any write at the same edge lands
    always_ff @(posedge clk) begin
        if (s_rd_en) begin
            s_rd_data <= mem[s_rd_addr];
        end
    end

endmodule : mem_ram_sdp

`default_nettype wire

/* mem_rd_aggregate.sv */
`timescale 1ns/10ps
`default_nettype none

// ===========================================================================
// Read side, request fan-out and word join
// ===========================================================================

module mem_rd_aggregate (
    input  wire logic                clk,
    input  wire logic                arst_n,
    // Init done from write side
    input  wire logic                rdy,
    // Controller read strobe
    input  wire logic                rd_en,
    input  wire mem_agg_pkg::addr_t  rd_addr,
    // Shared slice read port
    output logic                     s_rd_en,
    output mem_agg_pkg::addr_t       s_rd_addr,
    input  wire mem_agg_pkg::slice_t s_rd_data [mem_agg_pkg::N_SLICE],
    // Joined result
    output logic                     rd_vld,
    output mem_agg_pkg::word_t       rd_data
);

    // Stages before the output register
    // Stage 0 is the request to slices, stage 1 is slice data valid
    localparam int N_STAGE = mem_agg_pkg::RD_LATENCY - 1;

    logic               rd_acc;
    logic [N_STAGE-1:0] vld_q;
    mem_agg_pkg::word_t join_data;

    // Reads before rdy are dropped
    assign rd_acc = rd_en && rdy;

    // Request to every slice at once
    assign s_rd_en = vld_q[0];

    // -----------------------------------------------------------------------
    // Valid pipeline
    // -----------------------------------------------------------------------

    // Up to RD_LATENCY reads in flight, one bit each stage
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q  <= '0;
            rd_vld <= 1'b0;
        end else begin
            vld_q  <= {vld_q[N_STAGE-2:0], rd_acc};
            rd_vld <= vld_q[N_STAGE-1];
        end
    end

    // Request address, held with its strobe
    always_ff @(posedge clk) begin
        if (rd_acc) begin
            s_rd_addr <= rd_addr;
        end
    end

    // -----------------------------------------------------------------------
    // Word join
    // -----------------------------------------------------------------------

    // Slice 0 in the low bits
    always_comb begin
        join_data = '0;
        for (int i = 0; i < mem_agg_pkg::N_SLICE; i++) begin
            join_data[i*mem_agg_pkg::SLICE_WID +: mem_agg_pkg::SLICE_WID] = s_rd_data[i];
        end
    end

    // Output word, loaded when slice data is valid
    always_ff @(posedge clk) begin
        if (vld_q[N_STAGE-1]) begin
            rd_data <= join_data;
        end
    end

endmodule : mem_rd_aggregate

`default_nettype wire

/* mem_wr_aggregate.sv */
`timescale 1ns/10ps
`default_nettype none

// ===========================================================================
// Write side, init FSM and word split
// ===========================================================================

module mem_wr_aggregate (
    input  wire logic               clk,
    input  wire logic               arst_n,
    // Controller write strobe
    input  wire logic               wr_en,
    input  wire mem_agg_pkg::addr_t wr_addr,
    input  wire mem_agg_pkg::word_t wr_data,
    // Init done, memory usable
    output logic                    rdy,
    // Shared slice write port
    output logic                    s_wr_en,
    output mem_agg_pkg::addr_t      s_wr_addr,
    output mem_agg_pkg::slice_t     s_wr_data [mem_agg_pkg::N_SLICE]
);

    // Init sequencing
    typedef enum logic [1:0] {
        RESET,
        INIT,
        READY
    } state_t;

    state_t              state_q;
    state_t              state_d;
    mem_agg_pkg::addr_t  init_addr_q;
    logic                init_last;
    logic                wr_acc;

    // Last address of the clear sweep
    assign init_last = (init_addr_q == mem_agg_pkg::addr_t'(mem_agg_pkg::DEPTH - 1));

    // Controller writes count only once init is done
    assign wr_acc = wr_en && (state_q == READY);

    assign rdy = (state_q == READY);

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            RESET:   state_d = INIT;
            INIT:    if (init_last) state_d = READY;
            READY:   state_d = READY;
            default: state_d = RESET;
        endcase
    end

    // State, sweep counter, slice strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= RESET;
            init_addr_q <= '0;
            s_wr_en     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == INIT) begin
                init_addr_q <= init_addr_q + 1'b1;
            end
            // One write per cycle in INIT, else accepted strobes
            s_wr_en <= (state_q == INIT) || wr_acc;
        end
    end

    // Address and data to slices, zero during the sweep
    always_ff @(posedge clk) begin
        if (state_q == INIT) begin
            s_wr_addr <= init_addr_q;
            for (int i = 0; i < mem_agg_pkg::N_SLICE; i++) begin
                s_wr_data[i] <= '0;
            end
        end else begin
            s_wr_addr <= wr_addr;
            // Slice i takes bits i*SLICE_WID upward
            for (int i = 0; i < mem_agg_pkg::N_SLICE; i++) begin
                s_wr_data[i] <= wr_data[i*mem_agg_pkg::SLICE_WID +: mem_agg_pkg::SLICE_WID];
            end
        end
    end

endmodule : mem_wr_aggregate

`default_nettype wire

/* run.sh */
#!/bin/sh
# Compile and run the sliced memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=mem_aggregate_tb
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

rm -rf obj_dir
if [ $? -ne 0 ]; then
    echo "Could not clean obj_dir"
    exit 1
fi

# Build the simulator, assertions on, timing for the delays in the testbench
verilator --binary --assert --timing -Wno-fatal -j 0 \
    --top-module "$TOP" -f vlog.f
if [ $? -ne 0 ]; then
    echo "Compile failed"
    exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q -F '*** TEST FAILED ***' "$LOG"; then
    echo "RESULT: FAIL"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "RESULT: FAIL, simulator exit status $status"
    exit 1
fi

if ! grep -q -F '*** TEST PASSED ***' "$LOG"; then
    echo "RESULT: FAIL, no pass line in $LOG"
    exit 1
fi

echo "RESULT: PASS"
exit 0

/* vlog.f */
mem_agg_pkg.sv
mem_ram_sdp.sv
mem_wr_aggregate.sv
mem_rd_aggregate.sv
mem_aggregate.sv
mem_aggregate_properties.sv
mem_aggregate_tb.sv
